//--- include/imuldiv_macros.svh
// widths and apb register map for the mul/div unit
// register offsets assume an 8-bit byte address with word-aligned registers
`ifndef IMULDIV_MACROS_SVH
`define IMULDIV_MACROS_SVH

// operand width, results are twice this
`define IMULDIV_XLEN 32

// compute cycles per operation, one bit per cycle
`define IMULDIV_ITERS 32

// apb address width
`define IMULDIV_APB_AW 8

// --------------------
// register offsets
// --------------------
`define IMULDIV_ADDR_A      8'h00
`define IMULDIV_ADDR_B      8'h04
// write only: bit 0 start, bits 2:1 opcode
`define IMULDIV_ADDR_CTRL   8'h08
// read only: bit 0 busy, bit 1 done
`define IMULDIV_ADDR_STATUS 8'h0C
`define IMULDIV_ADDR_RES_LO 8'h10
`define IMULDIV_ADDR_RES_HI 8'h14

`endif

//--- design/imuldiv_pkg.sv
// opcode and word types shared by the mul/div unit
// opcode value 3 is illegal and never reaches the execution units
`default_nettype none

`include "imuldiv_macros.svh"

package imuldiv_pkg;

  // operation select, carried from the ctrl register bits 2:1
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } imuldiv_op_e;

  // operand and apb data word
  typedef logic [`IMULDIV_XLEN-1:0] word_t;

  // full result
  // for division the remainder is the high word, quotient the low word
  typedef logic [2*`IMULDIV_XLEN-1:0] dword_t;

endpackage

`default_nettype wire

//--- design/imuldiv_ifs.sv
// request and response handshakes inside the mul/div unit
// a transfer happens when val and rdy are both high; payload holds until then
`timescale 1ns/1ps
`default_nettype none

// --------------------
// request, decode to execute
// --------------------
interface muldiv_req_if;
  logic                     val;
  logic                     rdy;
  imuldiv_pkg::imuldiv_op_e op;
  imuldiv_pkg::word_t       a;
  imuldiv_pkg::word_t       b;

  modport src (output val, output op, output a, output b, input rdy);
  modport snk (input val, input op, input a, input b, output rdy);
endinterface

// --------------------
// response, execute to result
// --------------------
interface muldiv_resp_if;
  logic                val;
  logic                rdy;
  imuldiv_pkg::dword_t result;
  // high from request acceptance until the response transfer
  logic                busy;

  modport src (output val, output result, output busy, input rdy);
  modport snk (input val, input result, input busy, output rdy);
endinterface

`default_nettype wire

//--- design/imuldiv_mul_iterative.sv
// signed shift-add multiplier, one multiplier bit per cycle
// start loads the operands, done follows after the fixed iteration count
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_mul_iterative (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  imuldiv_pkg::word_t  a,
  input  imuldiv_pkg::word_t  b,
  output imuldiv_pkg::dword_t result,
  output logic                done,
  input  logic                ack
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e              state_q;
  logic [5:0]          cnt_q;
  // multiplicand widens as it shifts left
  imuldiv_pkg::dword_t mcand_q;
  imuldiv_pkg::word_t  mplier_q;
  imuldiv_pkg::dword_t acc_q;
  logic                neg_q;
  imuldiv_pkg::word_t  a_mag;
  imuldiv_pkg::word_t  b_mag;

  // magnitudes, the most negative value maps onto itself as unsigned
  assign a_mag = a[`IMULDIV_XLEN-1] ? (~a + 1'b1) : a;
  assign b_mag = b[`IMULDIV_XLEN-1] ? (~b + 1'b1) : b;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q <= st_calc;
            cnt_q   <= '0;
          end
        end
        st_calc: begin
          if (cnt_q == 6'(`IMULDIV_ITERS - 1)) begin
            state_q <= st_done;
          end
          cnt_q <= cnt_q + 6'd1;
        end
        st_done: begin
          if (ack) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------
  always_ff @(posedge clk) begin
    if (state_q == st_idle && start) begin
      mcand_q  <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      mplier_q <= b_mag;
      acc_q    <= '0;
      neg_q    <= a[`IMULDIV_XLEN-1] ^ b[`IMULDIV_XLEN-1];
    end else if (state_q == st_calc) begin
      // add the shifted multiplicand when this multiplier bit is set
      if (mplier_q[0]) begin
        acc_q <= acc_q + mcand_q;
      end
      mcand_q  <= mcand_q << 1;
      mplier_q <= mplier_q >> 1;
    end
  end

  // negative exactly when one operand sign is set
  assign result = neg_q ? (~acc_q + 1'b1) : acc_q;
  assign done   = (state_q == st_done);

endmodule

`default_nettype wire

//--- design/imuldiv_div_iterative.sv
// restoring divider, one quotient bit per cycle, signed or unsigned
// divide by zero gives all ones and the dividend as remainder
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_div_iterative (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  logic                is_signed,
  input  imuldiv_pkg::word_t  a,
  input  imuldiv_pkg::word_t  b,
  output imuldiv_pkg::dword_t result,
  output logic                done,
  input  logic                ack
);

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } state_e;

  state_e                  state_q;
  logic [5:0]              cnt_q;
  // remainder in the high half, dividend then quotient in the low half
  imuldiv_pkg::dword_t     rq_q;
  imuldiv_pkg::word_t      dvs_q;
  imuldiv_pkg::word_t      dvd_q;
  logic                    q_neg_q;
  logic                    r_neg_q;
  logic                    zero_q;
  logic                    sa;
  logic                    sb;
  imuldiv_pkg::word_t      a_mag;
  imuldiv_pkg::word_t      b_mag;
  logic [`IMULDIV_XLEN:0]  hi;
  logic [`IMULDIV_XLEN:0]  diff;
  imuldiv_pkg::word_t      quot;
  imuldiv_pkg::word_t      rem;

  // sign bits only count for signed division
  assign sa    = is_signed && a[`IMULDIV_XLEN-1];
  assign sb    = is_signed && b[`IMULDIV_XLEN-1];
  assign a_mag = sa ? (~a + 1'b1) : a;
  assign b_mag = sb ? (~b + 1'b1) : b;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= st_idle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (start) begin
            state_q <= st_calc;
            cnt_q   <= '0;
          end
        end
        st_calc: begin
          if (cnt_q == 6'(`IMULDIV_ITERS - 1)) begin
            state_q <= st_done;
          end
          cnt_q <= cnt_q + 6'd1;
        end
        st_done: begin
          if (ack) begin
            state_q <= st_idle;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------
  // datapath
  // --------------------
  // shifted partial remainder, one bit wider than the divisor
  assign hi   = rq_q[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN-1];
  assign diff = hi - {1'b0, dvs_q};

  always_ff @(posedge clk) begin
    if (state_q == st_idle && start) begin
      rq_q    <= {{`IMULDIV_XLEN{1'b0}}, a_mag};
      dvs_q   <= b_mag;
      dvd_q   <= a;
      q_neg_q <= sa ^ sb;
      r_neg_q <= sa;
      zero_q  <= (b == '0);
    end else if (state_q == st_calc) begin
      // subtract when it fits, else keep the shifted value (restore)
      if (hi >= {1'b0, dvs_q}) begin
        rq_q <= {diff[`IMULDIV_XLEN-1:0], rq_q[`IMULDIV_XLEN-2:0], 1'b1};
      end else begin
        rq_q <= {hi[`IMULDIV_XLEN-1:0], rq_q[`IMULDIV_XLEN-2:0], 1'b0};
      end
    end
  end

  // overflow falls out naturally: the quotient magnitude wraps to the most negative value
  assign quot = q_neg_q ? (~rq_q[`IMULDIV_XLEN-1:0] + 1'b1) : rq_q[`IMULDIV_XLEN-1:0];
  // remainder follows the dividend sign
  assign rem  = r_neg_q ? (~rq_q[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN] + 1'b1)
                        : rq_q[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];

  assign result = zero_q ? {dvd_q, {`IMULDIV_XLEN{1'b1}}} : {rem, quot};
  assign done   = (state_q == st_done);

  // full iteration count before any done
  a_no_early_done: assert property (@(posedge clk) disable iff (reset)
    start |=> !done [*`IMULDIV_ITERS]);

endmodule

`default_nettype wire

//--- design/imuldiv_execute.sv
// routes one request to the multiplier or the divider and returns its result
// units sample the operands one cycle after acceptance, so no operand copy here
`timescale 1ns/1ps
`default_nettype none

module imuldiv_execute (
  input  logic       clk,
  input  logic       reset,
  muldiv_req_if.snk  req,
  muldiv_resp_if.src resp
);

  logic                busy_q;
  logic                start_q;
  // which unit is in flight
  logic                sel_div_q;
  logic                signed_q;
  logic                req_fire;
  logic                resp_fire;
  logic                mul_start;
  logic                div_start;
  logic                mul_done;
  logic                div_done;
  logic                mul_ack;
  logic                div_ack;
  imuldiv_pkg::dword_t mul_result;
  imuldiv_pkg::dword_t div_result;

  // idle means nothing in flight
  assign req.rdy   = !busy_q;
  assign req_fire  = req.val && req.rdy;
  assign resp_fire = resp.val && resp.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_q    <= 1'b0;
      start_q   <= 1'b0;
      sel_div_q <= 1'b0;
      signed_q  <= 1'b0;
    end else begin
      // start is delayed one cycle, this is the load cycle
      start_q <= req_fire;
      if (req_fire) begin
        busy_q    <= 1'b1;
        sel_div_q <= (req.op != imuldiv_pkg::op_mul);
        signed_q  <= (req.op == imuldiv_pkg::op_div);
      end else if (resp_fire) begin
        busy_q <= 1'b0;
      end
    end
  end

  assign mul_start = start_q && !sel_div_q;
  assign div_start = start_q && sel_div_q;
  assign mul_ack   = resp_fire && !sel_div_q;
  assign div_ack   = resp_fire && sel_div_q;

  imuldiv_mul_iterative mul0 (
    .clk    (clk),
    .reset  (reset),
    .start  (mul_start),
    .a      (req.a),
    .b      (req.b),
    .result (mul_result),
    .done   (mul_done),
    .ack    (mul_ack)
  );

  imuldiv_div_iterative div0 (
    .clk       (clk),
    .reset     (reset),
    .start     (div_start),
    .is_signed (signed_q),
    .a         (req.a),
    .b         (req.b),
    .result    (div_result),
    .done      (div_done),
    .ack       (div_ack)
  );

  // the finished unit holds done until acked, which gives back-pressure
  assign resp.val    = sel_div_q ? div_done : mul_done;
  assign resp.result = sel_div_q ? div_result : mul_result;
  assign resp.busy   = busy_q;

  a_one_unit: assert property (@(posedge clk) disable iff (reset)
    $onehot0({mul_start, div_start, mul_done, div_done}));

endmodule

`default_nettype wire

//--- design/imuldiv_result.sv
// keeps one finished result until software reads the high word
// a new response waits while done is set
`timescale 1ns/1ps
`default_nettype none

module imuldiv_result (
  input  logic                clk,
  input  logic                reset,
  muldiv_resp_if.snk          resp,
  input  logic                rd_hi_pulse,
  output logic                done,
  output imuldiv_pkg::dword_t result
);

  logic                done_q;
  imuldiv_pkg::dword_t result_q;
  logic                xfer;

  // room for exactly one unread result
  assign resp.rdy = !done_q;
  assign xfer     = resp.val && resp.rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_q   <= 1'b0;
      result_q <= '0;
    end else if (xfer) begin
      // a new result wins over a stale high-word read
      done_q   <= 1'b1;
      result_q <= resp.result;
    end else if (rd_hi_pulse) begin
      done_q <= 1'b0;
    end
  end

  assign done   = done_q;
  assign result = result_q;

  // a held response lands on the edge right after the high-word read, never with it
  a_held_resp_follows_read: assert property (@(posedge clk) disable iff (reset)
    (done && rd_hi_pulse && resp.val) |-> !xfer ##1 xfer);

endmodule

`default_nettype wire

//--- design/imuldiv_apb_decode.sv
// apb slave for the mul/div unit, no wait states, every access completes at once
// pslverr marks unmapped addresses, read-only writes, bad opcodes and early starts
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_apb_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_APB_AW-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  imuldiv_pkg::word_t         pwdata,
  output imuldiv_pkg::word_t         prdata,
  output logic                       pslverr,
  muldiv_req_if.src                  req,
  input  logic                       busy,
  input  logic                       done,
  input  imuldiv_pkg::dword_t        result,
  output logic                       rd_hi_pulse
);

  imuldiv_pkg::word_t       a_q;
  imuldiv_pkg::word_t       b_q;
  imuldiv_pkg::imuldiv_op_e op_q;
  logic                     req_val_q;
  logic                     access;
  logic                     mapped;
  logic                     read_only;
  logic                     is_ctrl;
  logic [1:0]               ctrl_op;
  logic                     start_blocked;
  logic                     err;
  logic                     wr_ok;

  // access phase of any transfer
  assign access  = psel && penable;
  assign is_ctrl = (paddr == `IMULDIV_ADDR_CTRL);
  assign ctrl_op = pwdata[2:1];

  // --------------------
  // read mux and map
  // --------------------
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    prdata    = '0;
    case (paddr)
      `IMULDIV_ADDR_A: prdata = a_q;
      `IMULDIV_ADDR_B: prdata = b_q;
      // ctrl reads back as zero
      `IMULDIV_ADDR_CTRL: prdata = '0;
      `IMULDIV_ADDR_STATUS: begin
        read_only = 1'b1;
        // a pending request already counts as busy
        prdata[0] = busy || req_val_q;
        prdata[1] = done;
      end
      `IMULDIV_ADDR_RES_LO: begin
        read_only = 1'b1;
        prdata    = result[`IMULDIV_XLEN-1:0];
      end
      `IMULDIV_ADDR_RES_HI: begin
        read_only = 1'b1;
        prdata    = result[2*`IMULDIV_XLEN-1:`IMULDIV_XLEN];
      end
      default: mapped = 1'b0;
    endcase
  end

  // one request at a time, pending or in flight
  assign start_blocked = is_ctrl && pwdata[0] && (req_val_q || busy);

  assign err = !mapped
            || (pwrite && (read_only || (is_ctrl && ctrl_op == 2'd3) || start_blocked));

  assign pslverr = access && err;
  // rejected writes change nothing
  assign wr_ok   = access && pwrite && !err;

  // done clears on the edge that ends the result high read
  assign rd_hi_pulse = access && !pwrite && (paddr == `IMULDIV_ADDR_RES_HI);

  // --------------------
  // operands and request
  // --------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      a_q       <= '0;
      b_q       <= '0;
      op_q      <= imuldiv_pkg::op_mul;
      req_val_q <= 1'b0;
    end else begin
      if (req_val_q && req.rdy) begin
        req_val_q <= 1'b0;
      end
      if (wr_ok) begin
        case (paddr)
          `IMULDIV_ADDR_A: a_q <= pwdata;
          `IMULDIV_ADDR_B: b_q <= pwdata;
          `IMULDIV_ADDR_CTRL: begin
            if (pwdata[0]) begin
              req_val_q <= 1'b1;
              op_q      <= imuldiv_pkg::imuldiv_op_e'(ctrl_op);
            end
          end
          default: ;
        endcase
      end
    end
  end

  assign req.val = req_val_q;
  assign req.op  = op_q;
  assign req.a   = a_q;
  assign req.b   = b_q;

  // execute may stall; the offered request must not move under it
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    (req.val && !req.rdy) |=> (req.val && $stable({req.op, req.a, req.b})));

endmodule

`default_nettype wire

//--- design/imuldiv_top.sv
// top of the apb mul/div unit
// apb without pready, pprot or pstrb; no interrupt, poll status for done
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`IMULDIV_APB_AW-1:0] paddr,
  input  logic                       psel,
  input  logic                       penable,
  input  logic                       pwrite,
  input  imuldiv_pkg::word_t         pwdata,
  output imuldiv_pkg::word_t         prdata,
  output logic                       pslverr
);

  muldiv_req_if  req_if0 ();
  muldiv_resp_if resp_if0 ();

  logic                done;
  imuldiv_pkg::dword_t result;
  logic                rd_hi_pulse;

  // --------------------
  // register decode
  // --------------------
  imuldiv_apb_decode decode0 (
    .clk         (clk),
    .reset       (reset),
    .paddr       (paddr),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pslverr     (pslverr),
    .req         (req_if0.src),
    .busy        (resp_if0.busy),
    .done        (done),
    .result      (result),
    .rd_hi_pulse (rd_hi_pulse)
  );

  // mul and div units
  imuldiv_execute exec0 (
    .clk   (clk),
    .reset (reset),
    .req   (req_if0.snk),
    .resp  (resp_if0.src)
  );

  // result holding
  imuldiv_result result0 (
    .clk         (clk),
    .reset       (reset),
    .resp        (resp_if0.snk),
    .rd_hi_pulse (rd_hi_pulse),
    .done        (done),
    .result      (result)
  );

endmodule

`default_nettype wire

//--- include/imuldiv_tb_vectors.svh
// directed mul/div cases, included inside the testbench module body
// division results are {remainder, quotient}, products are full 64-bit
`ifndef IMULDIV_TB_VECTORS_SVH
`define IMULDIV_TB_VECTORS_SVH

localparam int num_vec = 24;

// columns: opcode, a, b, expected 64-bit result
task automatic load_vectors();
  // --------------------
  // signed multiply
  // --------------------
  add_vec(imuldiv_pkg::op_mul,  32'h0000_0003, 32'h0000_0005, 64'h0000_0000_0000_000f);
  add_vec(imuldiv_pkg::op_mul,  32'hffff_fffd, 32'h0000_0005, 64'hffff_ffff_ffff_fff1);
  add_vec(imuldiv_pkg::op_mul,  32'hffff_fff9, 32'hffff_fffa, 64'h0000_0000_0000_002a);
  add_vec(imuldiv_pkg::op_mul,  32'h0000_0000, 32'h1234_5678, 64'h0000_0000_0000_0000);
  // most negative squared
  add_vec(imuldiv_pkg::op_mul,  32'h8000_0000, 32'h8000_0000, 64'h4000_0000_0000_0000);
  add_vec(imuldiv_pkg::op_mul,  32'h7fff_ffff, 32'h7fff_ffff, 64'h3fff_ffff_0000_0001);
  add_vec(imuldiv_pkg::op_mul,  32'h8000_0000, 32'h0000_0001, 64'hffff_ffff_8000_0000);
  add_vec(imuldiv_pkg::op_mul,  32'hffff_ffff, 32'hffff_ffff, 64'h0000_0000_0000_0001);
  add_vec(imuldiv_pkg::op_mul,  32'h0001_0000, 32'hffff_0000, 64'hffff_ffff_0000_0000);
  // --------------------
  // signed divide
  // --------------------
  add_vec(imuldiv_pkg::op_div,  32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000e);
  add_vec(imuldiv_pkg::op_div,  32'hffff_ff9c, 32'h0000_0007, 64'hffff_fffe_ffff_fff2);
  add_vec(imuldiv_pkg::op_div,  32'h0000_0064, 32'hffff_fff9, 64'h0000_0002_ffff_fff2);
  add_vec(imuldiv_pkg::op_div,  32'hffff_ff9c, 32'hffff_fff9, 64'hffff_fffe_0000_000e);
  // divide by zero keeps the dividend as remainder
  add_vec(imuldiv_pkg::op_div,  32'h1234_5678, 32'h0000_0000, 64'h1234_5678_ffff_ffff);
  add_vec(imuldiv_pkg::op_div,  32'hffff_fff6, 32'h0000_0000, 64'hffff_fff6_ffff_ffff);
  // overflow, most negative over minus one
  add_vec(imuldiv_pkg::op_div,  32'h8000_0000, 32'hffff_ffff, 64'h0000_0000_8000_0000);
  add_vec(imuldiv_pkg::op_div,  32'h0000_0007, 32'h0000_0064, 64'h0000_0007_0000_0000);
  add_vec(imuldiv_pkg::op_div,  32'hffff_fff9, 32'h0000_0064, 64'hffff_fff9_0000_0000);
  // --------------------
  // unsigned divide
  // --------------------
  add_vec(imuldiv_pkg::op_divu, 32'hffff_ffff, 32'h0000_0002, 64'h0000_0001_7fff_ffff);
  add_vec(imuldiv_pkg::op_divu, 32'h8000_0000, 32'hffff_ffff, 64'h8000_0000_0000_0000);
  add_vec(imuldiv_pkg::op_divu, 32'h0000_0064, 32'h0000_0007, 64'h0000_0002_0000_000e);
  add_vec(imuldiv_pkg::op_divu, 32'hdead_beef, 32'h0000_0000, 64'hdead_beef_ffff_ffff);
  add_vec(imuldiv_pkg::op_divu, 32'hffff_fff6, 32'hffff_fffb, 64'hffff_fff6_0000_0000);
  add_vec(imuldiv_pkg::op_divu, 32'h1234_5678, 32'h0000_0010, 64'h0000_0008_0123_4567);
endtask

`endif

//--- test/imuldiv_tb.sv
// testbench for the apb mul/div unit, apb driven on the falling edge
// expected results come from the directed table and from a 64-bit software model
`timescale 1ns/1ps
`default_nettype none

`include "imuldiv_macros.svh"

module imuldiv_tb;

  localparam int num_random = 200;
  // extra operations in the status and back-pressure checks
  localparam int num_extra = 4;
  // compute bound plus the apb transfers and polls of one operation
  localparam int op_cycles = 40 + 10 * 3;

  logic                       clk;
  logic                       reset;
  logic [`IMULDIV_APB_AW-1:0] paddr;
  logic                       psel;
  logic                       penable;
  logic                       pwrite;
  imuldiv_pkg::word_t         pwdata;
  imuldiv_pkg::word_t         prdata;
  logic                       pslverr;
  logic [31:0]                lfsr_q;

  // directed table columns
  imuldiv_pkg::imuldiv_op_e vec_op[$];
  imuldiv_pkg::word_t       vec_a[$];
  imuldiv_pkg::word_t       vec_b[$];
  imuldiv_pkg::dword_t      vec_exp[$];

  imuldiv_top dut0 (
    .clk     (clk),
    .reset   (reset),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pslverr (pslverr)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // checks
  // --------------------
  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input imuldiv_pkg::word_t got,
                            input imuldiv_pkg::word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_dword(input string name, input imuldiv_pkg::dword_t got,
                             input imuldiv_pkg::dword_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%016h expected 0x%016h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%01h expected 0x%01h", name, got, exp);
      stop_on_error();
    end
  endtask

  // --------------------
  // apb transfers
  // --------------------
  // setup, access, then one idle cycle; outputs sampled mid access phase
  task automatic apb_xfer(input logic wr, input logic [`IMULDIV_APB_AW-1:0] addr,
                          input imuldiv_pkg::word_t wdata, input logic exp_err,
                          output imuldiv_pkg::word_t rdata);
    @(negedge clk);
    paddr   = addr;
    pwrite  = wr;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #2;
    rdata = prdata;
    check_err("pslverr", pslverr, exp_err);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [`IMULDIV_APB_AW-1:0] addr,
                           input imuldiv_pkg::word_t data, input logic exp_err);
    imuldiv_pkg::word_t unused;
    apb_xfer(1'b1, addr, data, exp_err, unused);
  endtask

  task automatic apb_read(input logic [`IMULDIV_APB_AW-1:0] addr,
                          output imuldiv_pkg::word_t data);
    apb_xfer(1'b0, addr, '0, 1'b0, data);
  endtask

  task automatic start_op(input imuldiv_pkg::imuldiv_op_e op, input imuldiv_pkg::word_t a,
                          input imuldiv_pkg::word_t b);
    apb_write(`IMULDIV_ADDR_A, a, 1'b0);
    apb_write(`IMULDIV_ADDR_B, b, 1'b0);
    apb_write(`IMULDIV_ADDR_CTRL, {29'd0, op, 1'b1}, 1'b0);
  endtask

  // poll status until done, the watchdog bounds it
  task automatic wait_done();
    imuldiv_pkg::word_t st;
    st = '0;
    while (!st[1]) begin
      apb_read(`IMULDIV_ADDR_STATUS, st);
    end
  endtask

  task automatic read_result(output imuldiv_pkg::dword_t res);
    imuldiv_pkg::word_t lo;
    imuldiv_pkg::word_t hi;
    apb_read(`IMULDIV_ADDR_RES_LO, lo);
    // high word last, this read frees the result slot
    apb_read(`IMULDIV_ADDR_RES_HI, hi);
    res = {hi, lo};
  endtask

  task automatic run_op(input imuldiv_pkg::imuldiv_op_e op, input imuldiv_pkg::word_t a,
                        input imuldiv_pkg::word_t b, output imuldiv_pkg::dword_t res);
    start_op(op, a, b);
    wait_done();
    read_result(res);
  endtask

  // --------------------
  // stimulus sources
  // --------------------
  task automatic add_vec(input imuldiv_pkg::imuldiv_op_e op, input imuldiv_pkg::word_t a,
                         input imuldiv_pkg::word_t b, input imuldiv_pkg::dword_t exp);
    vec_op.push_back(op);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_exp.push_back(exp);
  endtask

`include "imuldiv_tb_vectors.svh"

  // fibonacci lfsr, taps 32 22 2 1, one step per bit taken
  function automatic imuldiv_pkg::word_t rand_bits(input int n);
    imuldiv_pkg::word_t v;
    logic               fb;
    int                 i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // reference from the arithmetic rules, with native 64-bit math
  function automatic imuldiv_pkg::dword_t model_result(input imuldiv_pkg::imuldiv_op_e op,
                                                       input imuldiv_pkg::word_t a,
                                                       input imuldiv_pkg::word_t b);
    longint          sa;
    longint          sb;
    longint          sq;
    longint          sr;
    longint unsigned uq;
    longint unsigned ur;
    sa = $signed(a);
    sb = $signed(b);
    if (op == imuldiv_pkg::op_mul) begin
      return sa * sb;
    end
    if (b == '0) begin
      return {a, 32'hffff_ffff};
    end
    if (op == imuldiv_pkg::op_div) begin
      if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        return {32'h0, 32'h8000_0000};
      end
      // truncating division, remainder keeps the dividend sign
      sq = sa / sb;
      sr = sa % sb;
      return {sr[31:0], sq[31:0]};
    end
    uq = {32'h0, a} / {32'h0, b};
    ur = {32'h0, a} % {32'h0, b};
    return {ur[31:0], uq[31:0]};
  endfunction

  // --------------------
  // watchdog
  // --------------------
  initial begin : watchdog
    int timeout_cycles;
    timeout_cycles = (num_vec + num_random + num_extra) * op_cycles + 200;
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", timeout_cycles);
    stop_on_error();
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin : main
    int                       i;
    imuldiv_pkg::word_t       rd;
    imuldiv_pkg::word_t       ra;
    imuldiv_pkg::word_t       rb;
    imuldiv_pkg::dword_t      res;
    imuldiv_pkg::imuldiv_op_e op;
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    lfsr_q  = 32'h10c3;
    load_vectors();
    repeat (10) @(negedge clk);
    reset = 1'b0;

    // idle status after reset
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h0);

    // rejected writes leave the operands alone
    apb_write(`IMULDIV_ADDR_A, 32'h1111_1111, 1'b0);
    apb_write(`IMULDIV_ADDR_B, 32'h2222_2222, 1'b0);
    apb_write(8'h18, 32'hdead_0001, 1'b1);
    apb_write(`IMULDIV_ADDR_RES_LO, 32'hdead_0002, 1'b1);
    apb_write(`IMULDIV_ADDR_STATUS, 32'hdead_0003, 1'b1);
    // opcode 3 with start set
    apb_write(`IMULDIV_ADDR_CTRL, 32'h0000_0007, 1'b1);
    apb_read(`IMULDIV_ADDR_A, rd);
    check_word("a", rd, 32'h1111_1111);
    apb_read(`IMULDIV_ADDR_B, rd);
    check_word("b", rd, 32'h2222_2222);
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h0);

    // directed table
    for (i = 0; i < vec_op.size(); i++) begin
      run_op(vec_op[i], vec_a[i], vec_b[i], res);
      check_dword("result", res, vec_exp[i]);
    end

    // busy right after start, and a second start is refused
    start_op(imuldiv_pkg::op_divu, 32'h0000_1234, 32'h0000_0010);
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h1);
    apb_write(`IMULDIV_ADDR_CTRL, {29'd0, imuldiv_pkg::op_mul, 1'b1}, 1'b1);
    wait_done();

    // second op finishes behind the unread first result
    start_op(imuldiv_pkg::op_mul, 32'hffff_fff0, 32'h0000_0100);
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h3);
    repeat (`IMULDIV_ITERS + 8) @(negedge clk);
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h3);
    read_result(res);
    check_dword("result", res, 64'h0000_0004_0000_0123);
    wait_done();
    read_result(res);
    check_dword("result", res, 64'hffff_ffff_ffff_f000);
    apb_read(`IMULDIV_ADDR_STATUS, rd);
    check_word("status", rd, 32'h0);

    // random operands and opcodes
    for (i = 0; i < num_random; i++) begin
      op = imuldiv_pkg::imuldiv_op_e'(2'(rand_bits(2) % 3));
      ra = rand_bits(32);
      rb = rand_bits(32);
      // small divisors now and then, zero included
      if (rand_bits(2) == '0) begin
        rb = rb & 32'h0000_00ff;
      end
      run_op(op, ra, rb, res);
      check_dword("result", res, model_result(op, ra, rb));
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+include
design/imuldiv_pkg.sv
design/imuldiv_ifs.sv
design/imuldiv_mul_iterative.sv
design/imuldiv_div_iterative.sv
design/imuldiv_execute.sv
design/imuldiv_result.sv
design/imuldiv_apb_decode.sv
design/imuldiv_top.sv
test/imuldiv_tb.sv
